/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int data_width = 32;
	localparam int reg_addr_width = 5;

	// instruction field positions
	localparam int opcode_lsb = 25;
	localparam int rt_lsb = 20;
	localparam int ra_lsb = 15;
	localparam int rb_lsb = 10;
	localparam int sv_lsb = 8;
	localparam int branch_bit = 14;

	typedef enum logic [5:0] {
		op_ty_base = 6'b100000,
		op_addi    = 6'b101000,
		op_ori     = 6'b101100,
		op_xori    = 6'b101011,
		op_movi    = 6'b100010,
		op_lwi     = 6'b000010,
		op_swi     = 6'b001010,
		op_ty_ls   = 6'b011100,
		op_ty_b    = 6'b100110,
		op_jj      = 6'b100100
	} opcode_e;

	typedef enum logic [4:0] {
		sub_add   = 5'b00000,
		sub_sub   = 5'b00001,
		sub_and   = 5'b00010,
		sub_xor   = 5'b00011,
		sub_or    = 5'b00100,
		sub_slli  = 5'b01000,
		sub_srli  = 5'b01001,
		sub_rotri = 5'b01011
	} base_subop_e;

	typedef enum logic [7:0] {
		ls_lw = 8'b00000010,
		ls_sw = 8'b00001010
	} ls_subop_e;

	typedef enum logic {
		br_beq = 1'b0,
		br_bne = 1'b1
	} branch_e;

	typedef enum logic [2:0] {
		ph_fetch,
		ph_decode,
		ph_execute,
		ph_memaccess,
		ph_writeback
	} phase_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_srl,
		alu_sll,
		alu_ror
	} alu_op_e;

	typedef enum logic [1:0] {
		src2_reg,
		src2_imm,
		src2_shifted_rb,
		src2_word_offset
	} src2_sel_e;

	typedef enum logic [1:0] {
		ext_zero5,
		ext_sign15,
		ext_zero15,
		ext_sign20
	} ext_sel_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem
	} wb_sel_e;

	typedef enum logic [1:0] {
		pc_seq,
		pc_branch,
		pc_jump
	} pc_sel_e;

endpackage

`default_nettype wire

/* hw/ctrl_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface ctrl_if
	import cpu_pkg::*;
();

	logic [data_width-1:0] instr;
	logic alu_zero;

	alu_op_e alu_op;
	src2_sel_e src2_sel;
	ext_sel_e ext_sel;
	wb_sel_e wb_sel;
	pc_sel_e pc_sel;
	logic mem_read;
	logic mem_write;
	logic reg_write;

	modport datapath (
		output instr, alu_zero,
		input alu_op, src2_sel, ext_sel, wb_sel, pc_sel, mem_read, mem_write, reg_write
	);

	modport decoder (
		input instr, alu_zero,
		output alu_op, src2_sel, ext_sel, wb_sel, pc_sel, mem_read, mem_write, reg_write
	);

endinterface

`default_nettype wire

/* hw/phase_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module phase_sequencer
	import cpu_pkg::*;
(
	input wire clock,
	input wire reset,
	output phase_e phase
);

	phase_e next_phase;

	always_comb begin
		case (phase)
			ph_fetch: next_phase = ph_decode;
			ph_decode: next_phase = ph_execute;
			ph_execute: next_phase = ph_memaccess;
			ph_memaccess: next_phase = ph_writeback;
			ph_writeback: next_phase = ph_fetch;
			// unused encodings recover
			default: next_phase = ph_fetch;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= ph_fetch;
		end else begin
			phase <= next_phase;
		end
	end

	// fetch comes back exactly every fifth cycle
	fetch_cadence: assert property (
		@(posedge clock) disable iff (reset)
		!reset && phase == ph_fetch |=> (phase != ph_fetch) [*4] ##1 (phase == ph_fetch)
	);

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder
	import cpu_pkg::*;
(
	ctrl_if.decoder ctrl
);

	opcode_e opcode;
	base_subop_e base_subop;
	ls_subop_e ls_subop;
	branch_e branch_op;

	assign opcode = opcode_e'(ctrl.instr[opcode_lsb +: $bits(opcode_e)]);
	assign base_subop = base_subop_e'(ctrl.instr[$bits(base_subop_e)-1:0]);
	assign ls_subop = ls_subop_e'(ctrl.instr[$bits(ls_subop_e)-1:0]);
	assign branch_op = branch_e'(ctrl.instr[branch_bit]);

	always_comb begin
		// no-op unless the encoding is recognised
		ctrl.alu_op = alu_add;
		ctrl.src2_sel = src2_reg;
		ctrl.ext_sel = ext_zero5;
		ctrl.wb_sel = wb_alu;
		ctrl.mem_read = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.reg_write = 1'b0;
		case (opcode)
			op_ty_base: begin
				ctrl.reg_write = 1'b1;
				case (base_subop)
					sub_add: ctrl.alu_op = alu_add;
					sub_sub: ctrl.alu_op = alu_sub;
					sub_and: ctrl.alu_op = alu_and;
					sub_xor: ctrl.alu_op = alu_xor;
					sub_or: ctrl.alu_op = alu_or;
					sub_slli: begin
						ctrl.alu_op = alu_sll;
						ctrl.src2_sel = src2_imm;
					end
					sub_srli: begin
						ctrl.alu_op = alu_srl;
						ctrl.src2_sel = src2_imm;
					end
					sub_rotri: begin
						ctrl.alu_op = alu_ror;
						ctrl.src2_sel = src2_imm;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			op_addi: begin
				ctrl.src2_sel = src2_imm;
				ctrl.ext_sel = ext_sign15;
				ctrl.reg_write = 1'b1;
			end
			op_ori: begin
				ctrl.alu_op = alu_or;
				ctrl.src2_sel = src2_imm;
				ctrl.ext_sel = ext_zero15;
				ctrl.reg_write = 1'b1;
			end
			op_xori: begin
				ctrl.alu_op = alu_xor;
				ctrl.src2_sel = src2_imm;
				ctrl.ext_sel = ext_zero15;
				ctrl.reg_write = 1'b1;
			end
			op_movi: begin
				// sign20 also zeroes the first operand
				ctrl.src2_sel = src2_imm;
				ctrl.ext_sel = ext_sign20;
				ctrl.reg_write = 1'b1;
			end
			op_lwi: begin
				ctrl.src2_sel = src2_word_offset;
				ctrl.ext_sel = ext_sign15;
				ctrl.wb_sel = wb_mem;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_swi: begin
				ctrl.src2_sel = src2_word_offset;
				ctrl.ext_sel = ext_sign15;
				ctrl.mem_write = 1'b1;
			end
			op_ty_ls: begin
				ctrl.src2_sel = src2_shifted_rb;
				if (ls_subop == ls_lw) begin
					ctrl.wb_sel = wb_mem;
					ctrl.mem_read = 1'b1;
					ctrl.reg_write = 1'b1;
				end else if (ls_subop == ls_sw) begin
					ctrl.mem_write = 1'b1;
				end
			end
			// compare ra with rt
			op_ty_b: ctrl.alu_op = alu_sub;
			default: ctrl.alu_op = alu_add;
		endcase
	end

	always_comb begin
		case (opcode)
			op_ty_b: begin
				if ((branch_op == br_beq) && ctrl.alu_zero) begin
					ctrl.pc_sel = pc_branch;
				end else if ((branch_op == br_bne) && !ctrl.alu_zero) begin
					ctrl.pc_sel = pc_branch;
				end else begin
					ctrl.pc_sel = pc_seq;
				end
			end
			op_jj: ctrl.pc_sel = pc_jump;
			default: ctrl.pc_sel = pc_seq;
		endcase
	end

	mem_exclusive: assert property (
		@(ctrl.instr) !(ctrl.mem_read && ctrl.mem_write)
	);

endmodule

`default_nettype wire

/* hw/cpu_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_datapath
	import cpu_pkg::*;
#(
	parameter int pc_width = 12
) (
	input wire clock,
	input wire reset,
	input var phase_e phase,
	ctrl_if.datapath ctrl,
	input wire [data_width-1:0] im_data,
	input wire [data_width-1:0] dm_rdata,
	output logic [pc_width-1:0] im_addr,
	output logic im_read,
	output logic [pc_width-1:0] dm_addr,
	output logic [data_width-1:0] dm_wdata,
	output logic dm_read,
	output logic dm_write
);

	logic [pc_width-1:0] pc;
	logic [pc_width-1:0] pc_next;
	logic [reg_addr_width-1:0] ra_addr;
	logic [reg_addr_width-1:0] rb_addr;
	logic [reg_addr_width-1:0] rt_addr;
	logic [1:0] sv;
	logic [data_width-1:0] rf [2**reg_addr_width];
	logic [data_width-1:0] op_a;
	logic [data_width-1:0] op_b;
	logic [data_width-1:0] op_t;
	logic [data_width-1:0] ext_imm;
	logic [data_width-1:0] src2;
	logic [data_width-1:0] alu_a;
	logic [data_width-1:0] alu_out;
	logic [data_width-1:0] alu_q;
	logic [data_width-1:0] load_q;
	logic [data_width-1:0] wb_data;
	logic [data_width-1:0] br_off;
	logic [data_width-1:0] jmp_off;
	logic [4:0] shamt;

	assign ra_addr = ctrl.instr[ra_lsb +: reg_addr_width];
	assign rb_addr = ctrl.instr[rb_lsb +: reg_addr_width];
	assign rt_addr = ctrl.instr[rt_lsb +: reg_addr_width];
	assign sv = ctrl.instr[sv_lsb +: 2];

	assign im_addr = pc;
	assign im_read = (phase == ph_fetch);
	assign dm_addr = alu_q[pc_width+1:2];
	assign dm_wdata = op_t;
	assign dm_read = ctrl.mem_read && (phase == ph_memaccess);
	assign dm_write = ctrl.mem_write && (phase == ph_memaccess);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ctrl.instr <= '0;
		end else if (phase == ph_fetch) begin
			ctrl.instr <= im_data;
		end
	end

	always_ff @(posedge clock) begin
		if (phase == ph_decode) begin
			op_a <= rf[ra_addr];
			op_b <= rf[rb_addr];
			op_t <= rf[rt_addr];
		end
	end

	always_comb begin
		case (ctrl.ext_sel)
			ext_zero5: ext_imm = {{(data_width-5){1'b0}}, ctrl.instr[rb_lsb +: 5]};
			ext_sign15: ext_imm = {{(data_width-15){ctrl.instr[14]}}, ctrl.instr[14:0]};
			ext_zero15: ext_imm = {{(data_width-15){1'b0}}, ctrl.instr[14:0]};
			default: ext_imm = {{(data_width-20){ctrl.instr[19]}}, ctrl.instr[19:0]};
		endcase
		case (ctrl.src2_sel)
			src2_reg: src2 = op_b;
			src2_imm: src2 = ext_imm;
			src2_shifted_rb: src2 = op_b << sv;
			default: src2 = ext_imm << 2;
		endcase
	end

	// the movi ra field carries immediate bits
	assign alu_a = (ctrl.ext_sel == ext_sign20) ? '0 : op_a;
	assign shamt = src2[4:0];

	always_comb begin
		case (ctrl.alu_op)
			alu_add: alu_out = alu_a + src2;
			alu_sub: alu_out = alu_a - src2;
			alu_and: alu_out = alu_a & src2;
			alu_or: alu_out = alu_a | src2;
			alu_xor: alu_out = alu_a ^ src2;
			alu_srl: alu_out = alu_a >> shamt;
			alu_sll: alu_out = alu_a << shamt;
			default: alu_out = (alu_a >> shamt) | (alu_a << (data_width - shamt));
		endcase
	end

	always_ff @(posedge clock) begin
		if (phase == ph_execute) begin
			alu_q <= alu_out;
		end
		if (dm_read) begin
			load_q <= dm_rdata;
		end
	end

	// branch condition compares ra with rt
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ctrl.alu_zero <= 1'b0;
		end else if (phase == ph_execute) begin
			ctrl.alu_zero <= (op_a == op_t);
		end
	end

	assign wb_data = (ctrl.wb_sel == wb_mem) ? load_q : alu_q;

	always_ff @(posedge clock) begin
		if ((phase == ph_writeback) && ctrl.reg_write) begin
			rf[rt_addr] <= wb_data;
		end
	end

	// halfword-scaled offsets
	assign br_off = {{(data_width-15){ctrl.instr[13]}}, ctrl.instr[13:0], 1'b0};
	assign jmp_off = {{(data_width-25){ctrl.instr[23]}}, ctrl.instr[23:0], 1'b0};

	always_comb begin
		case (ctrl.pc_sel)
			pc_branch: pc_next = pc + br_off[pc_width-1:0];
			pc_jump: pc_next = pc + jmp_off[pc_width-1:0];
			default: pc_next = pc + pc_width'(4);
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (phase == ph_writeback) begin
			pc <= pc_next;
		end
	end

	// store lands three cycles after its fetch
	store_after_fetch: assert property (
		@(posedge clock) disable iff (reset)
		dm_write |-> $past(im_read, 3)
	);

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_core
	import cpu_pkg::*;
#(
	parameter int pc_width = 12
) (
	input wire clock,
	input wire reset,
	input wire [data_width-1:0] im_data,
	input wire [data_width-1:0] dm_rdata,
	output logic [pc_width-1:0] im_addr,
	output logic im_read,
	output logic [pc_width-1:0] dm_addr,
	output logic [data_width-1:0] dm_wdata,
	output logic dm_read,
	output logic dm_write
);

	phase_e phase;

	ctrl_if ctrl_bus ();

	phase_sequencer u_sequencer (
		.clock (clock),
		.reset (reset),
		.phase (phase)
	);

	instr_decoder u_decoder (
		.ctrl (ctrl_bus.decoder)
	);

	cpu_datapath #(
		.pc_width (pc_width)
	) u_datapath (
		.clock    (clock),
		.reset    (reset),
		.phase    (phase),
		.ctrl     (ctrl_bus.datapath),
		.im_data  (im_data),
		.dm_rdata (dm_rdata),
		.im_addr  (im_addr),
		.im_read  (im_read),
		.dm_addr  (dm_addr),
		.dm_wdata (dm_wdata),
		.dm_read  (dm_read),
		.dm_write (dm_write)
	);

endmodule

`default_nettype wire

/* sim/tb_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_memory
	import cpu_pkg::*;
#(
	parameter int pc_width = 12
) (
	input wire clock,
	input wire [pc_width-1:0] im_addr,
	input wire im_read,
	output logic [data_width-1:0] im_data,
	input wire [pc_width-1:0] dm_addr,
	input wire [data_width-1:0] dm_wdata,
	input wire dm_read,
	input wire dm_write,
	output logic [data_width-1:0] dm_rdata
);

	// instruction memory holds words, addressed by byte pc
	logic [data_width-1:0] imem [2**(pc_width-2)];
	logic [data_width-1:0] dmem [2**pc_width];

	assign im_data = im_read ? imem[im_addr[pc_width-1:2]] : '0;
	assign dm_rdata = dm_read ? dmem[dm_addr] : '0;

	always @(posedge clock) begin
		if (dm_write) begin
			dmem[dm_addr] <= dm_wdata;
		end
	end

endmodule

`default_nettype wire

/* sim/tb_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu
	import cpu_pkg::*;
();

	localparam int pc_width = 12;
	localparam int max_instr = 2**(pc_width-2);
	localparam int store_base = 'h200;

	typedef enum int {
		k_add, k_sub, k_and, k_or, k_xor, k_srli, k_slli, k_rotri, k_addi, k_ori,
		k_xori, k_movi, k_lwi, k_swi, k_lw, k_sw, k_beq, k_bne, k_j
	} kind_e;

	logic clock;
	logic reset;
	logic [data_width-1:0] im_data;
	logic [data_width-1:0] dm_rdata;
	logic [pc_width-1:0] im_addr;
	logic im_read;
	logic [pc_width-1:0] dm_addr;
	logic [data_width-1:0] dm_wdata;
	logic dm_read;
	logic dm_write;

	// program fields seen by the model
	kind_e p_kind [max_instr];
	int p_rt [max_instr];
	int p_ra [max_instr];
	int p_rb [max_instr];
	int p_imm [max_instr];
	string p_test [max_instr];
	int prog_len;
	int store_slot;
	string test_name;
	logic [31:0] lfsr_state;

	logic [data_width-1:0] model_rf [2**reg_addr_width];
	logic [data_width-1:0] model_dmem [2**pc_width];
	logic [pc_width-1:0] model_pc;
	logic [pc_width-1:0] halt_pc;
	logic store_pending;
	logic [pc_width-1:0] exp_addr;
	logic [data_width-1:0] exp_data;
	string current_test;
	logic finishing;
	int cycle_count;
	int cycle_limit;

	cpu_core #(
		.pc_width (pc_width)
	) dut (
		.clock    (clock),
		.reset    (reset),
		.im_data  (im_data),
		.dm_rdata (dm_rdata),
		.im_addr  (im_addr),
		.im_read  (im_read),
		.dm_addr  (dm_addr),
		.dm_wdata (dm_wdata),
		.dm_read  (dm_read),
		.dm_write (dm_write)
	);

	tb_memory #(
		.pc_width (pc_width)
	) mem (
		.clock    (clock),
		.im_addr  (im_addr),
		.im_read  (im_read),
		.im_data  (im_data),
		.dm_addr  (dm_addr),
		.dm_wdata (dm_wdata),
		.dm_read  (dm_read),
		.dm_write (dm_write),
		.dm_rdata (dm_rdata)
	);

	always #2 clock = ~clock;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic logic [31:0] fill_word(input int addr);
		logic [11:0] a;
		a = addr[11:0];
		return {a ^ 12'h5a3, 8'hc6, ~a};
	endfunction

	function automatic logic [31:0] encode(input kind_e kind, input int rt, input int ra,
			input int rb, input int imm);
		logic [4:0] t;
		logic [4:0] a;
		logic [4:0] b;
		t = rt[4:0];
		a = ra[4:0];
		b = rb[4:0];
		case (kind)
			k_add: return {1'b0, op_ty_base, t, a, b, 5'b0, sub_add};
			k_sub: return {1'b0, op_ty_base, t, a, b, 5'b0, sub_sub};
			k_and: return {1'b0, op_ty_base, t, a, b, 5'b0, sub_and};
			k_or: return {1'b0, op_ty_base, t, a, b, 5'b0, sub_or};
			k_xor: return {1'b0, op_ty_base, t, a, b, 5'b0, sub_xor};
			k_srli: return {1'b0, op_ty_base, t, a, imm[4:0], 5'b0, sub_srli};
			k_slli: return {1'b0, op_ty_base, t, a, imm[4:0], 5'b0, sub_slli};
			k_rotri: return {1'b0, op_ty_base, t, a, imm[4:0], 5'b0, sub_rotri};
			k_addi: return {1'b0, op_addi, t, a, imm[14:0]};
			k_ori: return {1'b0, op_ori, t, a, imm[14:0]};
			k_xori: return {1'b0, op_xori, t, a, imm[14:0]};
			k_movi: return {1'b0, op_movi, t, imm[19:0]};
			k_lwi: return {1'b0, op_lwi, t, a, imm[14:0]};
			k_swi: return {1'b0, op_swi, t, a, imm[14:0]};
			k_lw: return {1'b0, op_ty_ls, t, a, b, imm[1:0], ls_lw};
			k_sw: return {1'b0, op_ty_ls, t, a, b, imm[1:0], ls_sw};
			k_beq: return {1'b0, op_ty_b, t, a, br_beq, imm[13:0]};
			k_bne: return {1'b0, op_ty_b, t, a, br_bne, imm[13:0]};
			default: return {1'b0, op_jj, 1'b0, imm[23:0]};
		endcase
	endfunction

	task automatic emit(input kind_e kind, input int rt, input int ra, input int rb,
			input int imm);
		p_kind[prog_len] = kind;
		p_rt[prog_len] = rt;
		p_ra[prog_len] = ra;
		p_rb[prog_len] = rb;
		p_imm[prog_len] = imm;
		p_test[prog_len] = test_name;
		mem.imem[prog_len] <= encode(kind, rt, ra, rb, imm);
		prog_len++;
	endtask

	task automatic store_result(input int rt);
		emit(k_swi, rt, 0, 0, store_base + store_slot);
		store_slot++;
	endtask

	// full 32-bit constant in three steps
	task automatic load_word(input int rt, input logic [31:0] value);
		emit(k_movi, rt, 0, 0, value[31:12]);
		emit(k_slli, rt, rt, 0, 12);
		emit(k_ori, rt, rt, 0, value[11:0]);
	endtask

	task automatic build_program();
		logic [31:0] x;
		test_name = "alu_reg";
		emit(k_movi, 0, 0, 0, 0);
		load_word(1, random_bits(32));
		load_word(2, random_bits(32));
		emit(k_add, 3, 1, 2, 0);
		emit(k_sub, 4, 1, 2, 0);
		emit(k_and, 5, 1, 2, 0);
		emit(k_or, 6, 1, 2, 0);
		emit(k_xor, 7, 1, 2, 0);
		emit(k_srli, 8, 1, 0, random_bits(5));
		emit(k_slli, 9, 2, 0, random_bits(5));
		emit(k_rotri, 10, 1, 0, random_bits(5));
		for (int r = 1; r <= 10; r++) begin
			store_result(r);
		end
		test_name = "alu_imm";
		emit(k_addi, 11, 1, 0, 32'h4000 | random_bits(14));
		emit(k_ori, 12, 2, 0, 32'h4000 | random_bits(14));
		emit(k_xori, 13, 1, 0, 32'h4000 | random_bits(14));
		emit(k_movi, 14, 0, 0, 32'h80000 | random_bits(19));
		emit(k_addi, 15, 2, 0, 32'h7fff);
		for (int r = 11; r <= 15; r++) begin
			store_result(r);
		end
		test_name = "load";
		emit(k_lwi, 16, 0, 0, 'h100 + random_bits(6));
		store_result(16);
		// r17 points at word 0x100, r20 at the next store slots
		emit(k_movi, 17, 0, 0, 'h400);
		emit(k_movi, 20, 0, 0, (store_base + store_slot) * 4);
		for (int sv = 0; sv < 4; sv++) begin
			emit(k_movi, 19, 0, 0, (random_bits(4) << 2) >> sv);
			emit(k_lw, 18, 17, 19, sv);
			emit(k_movi, 21, 0, 0, sv);
			emit(k_sw, 18, 20, 21, 2);
		end
		store_slot += 4;
		test_name = "control";
		x = random_bits(19);
		emit(k_movi, 22, 0, 0, x);
		emit(k_movi, 23, 0, 0, x);
		emit(k_movi, 24, 0, 0, x ^ 1);
		emit(k_beq, 23, 22, 0, 4);
		store_result(22);
		emit(k_beq, 24, 22, 0, 4);
		store_result(23);
		emit(k_bne, 24, 22, 0, 4);
		store_result(24);
		emit(k_bne, 23, 22, 0, 4);
		store_result(22);
		emit(k_j, 0, 0, 0, 6);
		store_result(23);
		store_result(24);
		store_result(22);
		// jump to itself marks the end
		halt_pc = pc_width'(prog_len * 4);
		emit(k_j, 0, 0, 0, 0);
	endtask

	task automatic record_store(input logic [data_width-1:0] addr,
			input logic [data_width-1:0] data);
		store_pending = 1'b1;
		exp_addr = addr[pc_width+1:2];
		exp_data = data;
		model_dmem[addr[pc_width+1:2]] = data;
	endtask

	task automatic execute_model();
		int idx;
		int rt;
		logic [data_width-1:0] a;
		logic [data_width-1:0] b;
		logic [data_width-1:0] t;
		logic [data_width-1:0] imm;
		logic [data_width-1:0] addr;
		logic [data_width-1:0] offset;
		logic [2*data_width-1:0] doubled;
		logic [pc_width-1:0] next_pc;
		idx = int'(model_pc >> 2);
		if (idx >= prog_len) begin
			fail_run("the reference model ran past the end of the program");
		end else begin
			rt = p_rt[idx];
			a = model_rf[p_ra[idx]];
			b = model_rf[p_rb[idx]];
			t = model_rf[rt];
			imm = p_imm[idx];
			next_pc = model_pc + pc_width'(4);
			current_test = p_test[idx];
			case (p_kind[idx])
				k_add: model_rf[rt] = a + b;
				k_sub: model_rf[rt] = a - b;
				k_and: model_rf[rt] = a & b;
				k_or: model_rf[rt] = a | b;
				k_xor: model_rf[rt] = a ^ b;
				k_srli: model_rf[rt] = a >> imm[4:0];
				k_slli: model_rf[rt] = a << imm[4:0];
				k_rotri: begin
					doubled = {a, a} >> imm[4:0];
					model_rf[rt] = doubled[data_width-1:0];
				end
				k_addi: model_rf[rt] = a + {{17{imm[14]}}, imm[14:0]};
				k_ori: model_rf[rt] = a | {17'b0, imm[14:0]};
				k_xori: model_rf[rt] = a ^ {17'b0, imm[14:0]};
				k_movi: model_rf[rt] = {{12{imm[19]}}, imm[19:0]};
				k_lwi: begin
					addr = a + ({{17{imm[14]}}, imm[14:0]} << 2);
					model_rf[rt] = model_dmem[addr[pc_width+1:2]];
				end
				k_swi: record_store(a + ({{17{imm[14]}}, imm[14:0]} << 2), t);
				k_lw: begin
					addr = a + (b << imm[1:0]);
					model_rf[rt] = model_dmem[addr[pc_width+1:2]];
				end
				k_sw: record_store(a + (b << imm[1:0]), t);
				k_beq, k_bne: begin
					offset = {{17{imm[13]}}, imm[13:0], 1'b0};
					if ((a == t) == (p_kind[idx] == k_beq)) begin
						next_pc = model_pc + offset[pc_width-1:0];
					end
				end
				default: begin
					offset = {{7{imm[23]}}, imm[23:0], 1'b0};
					next_pc = model_pc + offset[pc_width-1:0];
				end
			endcase
			model_pc = next_pc;
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		lfsr_state = 32'h8e9c;
		model_pc = '0;
		store_pending = 1'b0;
		exp_addr = '0;
		exp_data = '0;
		finishing = 1'b0;
		cycle_count = 0;
		prog_len = 0;
		store_slot = 0;
		current_test = "reset";
		for (int i = 0; i < 2**reg_addr_width; i++) begin
			model_rf[i] = '0;
		end
		for (int i = 0; i < 2**pc_width; i++) begin
			model_dmem[i] = fill_word(i);
			mem.dmem[i] <= fill_word(i);
		end
		for (int i = 0; i < max_instr; i++) begin
			mem.imem[i] <= '0;
		end
		build_program();
		cycle_limit = prog_len * 5 + 50;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
	end

	always @(posedge clock) begin
		if (!reset) begin
			cycle_count++;
			if (finishing) begin
				$display("NO ERRORS");
				$finish;
			end else if (cycle_count > cycle_limit) begin
				fail_run("timeout: the program end was not reached within the cycle limit");
			end else begin
				if (dm_write) begin
					store_pending = 1'b0;
				end
				if (im_read) begin
					if (model_pc == halt_pc) begin
						finishing = 1'b1;
					end else begin
						execute_model();
					end
				end
			end
		end
	end

	fetch_every_fifth: assert property (@(posedge clock) disable iff (reset)
		!reset && im_read |=> !im_read [*4] ##1 im_read)
		else fail_run("im_read did not return exactly five cycles after a fetch");

	strobe_after_fetch: assert property (@(posedge clock) disable iff (reset)
		(dm_read || dm_write) |-> $past(im_read, 3))
		else fail_run("a data memory strobe came outside the memory phase");

	quiet_in_reset: assert property (@(posedge clock)
		reset |-> !dm_read && !dm_write)
		else fail_run("a data memory strobe was active during reset");

	first_fetch_strobe: assert property (@(posedge clock)
		$fell(reset) |-> im_read)
		else fail_run("no fetch in the first cycle after reset");

	first_fetch_address: assert property (@(posedge clock)
		$fell(reset) |-> im_addr == '0)
		else fail_run($sformatf("** Error [reset] first fetch address expected %h actual %h",
			pc_width'(0), $sampled(im_addr)));

	fetch_address: assert property (@(posedge clock) disable iff (reset)
		im_read |-> im_addr == model_pc)
		else fail_run($sformatf("** Error [%s] fetch address expected %h actual %h",
			current_test, $sampled(model_pc), $sampled(im_addr)));

	store_expected: assert property (@(posedge clock) disable iff (reset)
		dm_write |-> store_pending)
		else fail_run("a store came from an instruction that should not store");

	store_address: assert property (@(posedge clock) disable iff (reset)
		dm_write |-> dm_addr == exp_addr)
		else fail_run($sformatf("** Error [%s] store address expected %h actual %h",
			current_test, $sampled(exp_addr), $sampled(dm_addr)));

	store_data: assert property (@(posedge clock) disable iff (reset)
		dm_write |-> dm_wdata == exp_data)
		else fail_run($sformatf("** Error [%s] store data expected %h actual %h",
			current_test, $sampled(exp_data), $sampled(dm_wdata)));

	store_not_missed: assert property (@(posedge clock) disable iff (reset)
		im_read |-> !store_pending)
		else fail_run("an expected store did not happen before the next fetch");

endmodule

`default_nettype wire

/* sim.f */
hw/cpu_pkg.sv
hw/ctrl_if.sv
hw/phase_sequencer.sv
hw/instr_decoder.sv
hw/cpu_datapath.sv
hw/cpu_core.sv
sim/tb_memory.sv
sim/tb_cpu.sv
